// ==== rtl/axis_in_pkg.sv ====
package axis_in_pkg;

   // Packed word and register bus width
   localparam int CPU_DATA_W = 32;

   // Register port word address width
   localparam int ADDR_W = 3;

   // Register word addresses
   localparam logic [ADDR_W-1:0] REG_SOFT_RESET = 3'd0;
   localparam logic [ADDR_W-1:0] REG_ENABLE     = 3'd1;
   localparam logic [ADDR_W-1:0] REG_THRESHOLD  = 3'd2;
   localparam logic [ADDR_W-1:0] REG_STATUS     = 3'd3;
   localparam logic [ADDR_W-1:0] REG_DATA       = 3'd4;

   // STATUS field positions
   localparam int STATUS_LAST_BIT  = 4;
   localparam int STATUS_EMPTY_BIT = 5;
   localparam int STATUS_LEVEL_LSB = 16;

   // Packer FSM
   typedef enum logic {
      PACK_WRITE = 1'b0,
      PACK_PAD   = 1'b1
   } pack_state_t;

endpackage

// ==== rtl/axis_in_word_if.sv ====
`timescale 1ns/1ns

interface axis_in_word_if
   import axis_in_pkg::*;
#(
   parameter int LANES = 4
) ();

   logic                  push;
   logic [CPU_DATA_W-1:0] data;
   logic [LANES-1:0]      strb;
   logic                  last;
   logic                  full;

   // Packer side, never pushes while full
   modport producer(output push, output data, output strb, output last, input full);

   // Buffer side
   modport consumer(input push, input data, input strb, input last, output full);

endinterface

// ==== rtl/axis_in_packer.sv ====
`timescale 1ns/1ns

module axis_in_packer
   import axis_in_pkg::*;
#(
   parameter int TDATA_W = 8
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               clr_i,
   input  logic               enable_i,
   input  logic [TDATA_W-1:0] axis_tdata_i,
   input  logic               axis_tvalid_i,
   input  logic               axis_tlast_i,
   output logic               axis_tready_o,
   axis_in_word_if.producer   word
);

   localparam int LANES  = CPU_DATA_W / TDATA_W;
   localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

   pack_state_t           state_q;
   logic [LANE_W-1:0]     lane_q;
   logic [CPU_DATA_W-1:0] data_q;
   logic [LANES-1:0]      strb_q;

   logic [CPU_DATA_W-1:0] data_nxt;
   logic [LANES-1:0]      strb_nxt;
   logic                  can_step;
   logic                  accept;
   logic                  pad_step;
   logic                  advance;
   logic                  last_lane;

   // Buffer space, enabled and no soft clear in progress
   assign can_step = enable_i & ~word.full & ~clr_i;

   assign axis_tready_o = can_step & (state_q == PACK_WRITE);
   assign accept        = axis_tvalid_i & axis_tready_o;
   assign pad_step      = can_step & (state_q == PACK_PAD);
   assign advance       = accept | pad_step;
   assign last_lane     = (lane_q == LANE_W'(LANES - 1));

   // Current lane gets the beat, or zero while padding
   always_comb begin
      data_nxt = data_q;
      strb_nxt = strb_q;
      if (state_q == PACK_WRITE) begin
         data_nxt[lane_q*TDATA_W +: TDATA_W] = axis_tdata_i;
         strb_nxt[lane_q]                    = 1'b1;
      end else begin
         data_nxt[lane_q*TDATA_W +: TDATA_W] = '0;
         strb_nxt[lane_q]                    = 1'b0;
      end
   end

   // Word leaves on the edge that fills the top lane
   assign word.push = advance & last_lane;
   assign word.data = data_nxt;
   assign word.strb = strb_nxt;
   assign word.last = (state_q == PACK_PAD) | axis_tlast_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || clr_i) begin
         state_q <= PACK_WRITE;
         lane_q  <= '0;
      end else if (advance) begin
         if (last_lane) begin
            lane_q  <= '0;
            state_q <= PACK_WRITE;
         end else begin
            lane_q <= lane_q + 1'b1;
            // Early tlast, fill the rest with padding
            if (state_q == PACK_WRITE && axis_tlast_i) begin
               state_q <= PACK_PAD;
            end
         end
      end
   end

   // Partial word, every lane is rewritten before a push
   always_ff @(posedge clk_i) begin
      if (advance) begin
         data_q <= data_nxt;
         strb_q <= strb_nxt;
      end
   end

endmodule

// ==== rtl/axis_in_fifo.sv ====
`timescale 1ns/1ns

module axis_in_fifo
   import axis_in_pkg::*;
#(
   parameter int LANES           = 4,
   parameter int FIFO_DEPTH_LOG2 = 3
) (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic                       clr_i,
   axis_in_word_if.consumer           word,
   input  logic                       pop_i,
   output logic [CPU_DATA_W-1:0]      head_data_o,
   output logic [LANES-1:0]           head_strb_o,
   output logic                       head_last_o,
   output logic                       empty_o,
   output logic [FIFO_DEPTH_LOG2:0]   level_o
);

   localparam int DEPTH   = 1 << FIFO_DEPTH_LOG2;
   localparam int ENTRY_W = CPU_DATA_W + LANES + 1;

   // Entry layout {last, strb, data}
   logic [ENTRY_W-1:0]         mem [DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr_q;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_q;
   logic [FIFO_DEPTH_LOG2:0]   level_q;
   logic                       do_push;
   logic                       do_pop;

   assign empty_o   = (level_q == '0);
   assign word.full = (level_q == (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
   assign level_o   = level_q;

   assign do_push = word.push & ~word.full;
   // Pop on empty is dropped here
   assign do_pop  = pop_i & ~empty_o;

   // Show-ahead head
   assign head_data_o = mem[rd_ptr_q][CPU_DATA_W-1:0];
   assign head_strb_o = mem[rd_ptr_q][CPU_DATA_W +: LANES];
   assign head_last_o = mem[rd_ptr_q][ENTRY_W-1];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr_q] <= {word.last, word.strb, word.data};
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || clr_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

endmodule

// ==== rtl/axis_in_regs.sv ====
`timescale 1ns/1ns

module axis_in_regs
   import axis_in_pkg::*;
#(
   parameter int LANES           = 4,
   parameter int FIFO_DEPTH_LOG2 = 3
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     reg_avalid_i,
   input  logic [ADDR_W-1:0]        reg_addr_i,
   input  logic [CPU_DATA_W-1:0]    reg_wdata_i,
   input  logic                     reg_wen_i,
   output logic                     reg_ready_o,
   output logic                     reg_rvalid_o,
   output logic [CPU_DATA_W-1:0]    reg_rdata_o,
   input  logic [CPU_DATA_W-1:0]    head_data_i,
   input  logic [LANES-1:0]         head_strb_i,
   input  logic                     head_last_i,
   input  logic                     empty_i,
   input  logic [FIFO_DEPTH_LOG2:0] level_i,
   output logic                     pop_o,
   output logic                     clr_o,
   output logic                     enable_o,
   output logic [CPU_DATA_W-1:0]    tdata_o,
   output logic                     tvalid_o,
   input  logic                     tready_i,
   output logic                     fifo_threshold_o
);

   localparam int LEVEL_W = FIFO_DEPTH_LOG2 + 1;

   logic                  enable_q;
   logic [CPU_DATA_W-1:0] threshold_q;
   logic                  rvalid_q;
   logic [CPU_DATA_W-1:0] rdata_q;

   logic                  wr_access;
   logic                  rd_access;
   logic                  data_rd;
   logic                  dma_pop;
   logic [CPU_DATA_W-1:0] status;
   logic [CPU_DATA_W-1:0] rdata_mux;

   assign reg_ready_o = 1'b1;
   assign wr_access   = reg_avalid_i & reg_wen_i;
   assign rd_access   = reg_avalid_i & ~reg_wen_i;
   assign data_rd     = rd_access & (reg_addr_i == REG_DATA);

   // Soft clear acts on the write edge itself
   assign clr_o    = wr_access & (reg_addr_i == REG_SOFT_RESET) & reg_wdata_i[0];
   assign enable_o = enable_q;

   // DMA port
   assign tvalid_o = ~empty_i & enable_q;
   assign tdata_o  = head_data_i;
   assign dma_pop  = tvalid_o & tready_i;

   // A DATA read in the same cycle shares the DMA pop
   assign pop_o = dma_pop | (data_rd & ~empty_i);

   assign fifo_threshold_o = (CPU_DATA_W'(level_i) >= threshold_q);

   // Head fields are masked when there is no head word
   always_comb begin
      status = '0;
      if (!empty_i) begin
         status[LANES-1:0]       = head_strb_i;
         status[STATUS_LAST_BIT] = head_last_i;
      end
      status[STATUS_EMPTY_BIT]             = empty_i;
      status[STATUS_LEVEL_LSB +: LEVEL_W]  = level_i;
   end

   always_comb begin
      case (reg_addr_i)
         REG_ENABLE:    rdata_mux = CPU_DATA_W'(enable_q);
         REG_THRESHOLD: rdata_mux = threshold_q;
         REG_STATUS:    rdata_mux = status;
         REG_DATA:      rdata_mux = empty_i ? '0 : head_data_i;
         default:       rdata_mux = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         enable_q    <= 1'b0;
         threshold_q <= '1;
         rvalid_q    <= 1'b0;
      end else begin
         rvalid_q <= rd_access;
         if (wr_access && reg_addr_i == REG_ENABLE) begin
            enable_q <= reg_wdata_i[0];
         end
         if (wr_access && reg_addr_i == REG_THRESHOLD) begin
            threshold_q <= reg_wdata_i;
         end
      end
   end

   // Read data is captured with the access
   always_ff @(posedge clk_i) begin
      if (rd_access) begin
         rdata_q <= rdata_mux;
      end
   end

   assign reg_rvalid_o = rvalid_q;
   assign reg_rdata_o  = rdata_q;

endmodule

// ==== rtl/axis_in_top.sv ====
`timescale 1ns/1ns

module axis_in_top
   import axis_in_pkg::*;
#(
   parameter int TDATA_W         = 8,
   parameter int FIFO_DEPTH_LOG2 = 3
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic [TDATA_W-1:0]    axis_tdata_i,
   input  logic                  axis_tvalid_i,
   input  logic                  axis_tlast_i,
   output logic                  axis_tready_o,
   input  logic                  reg_avalid_i,
   input  logic [ADDR_W-1:0]     reg_addr_i,
   input  logic [CPU_DATA_W-1:0] reg_wdata_i,
   input  logic                  reg_wen_i,
   output logic                  reg_ready_o,
   output logic                  reg_rvalid_o,
   output logic [CPU_DATA_W-1:0] reg_rdata_o,
   output logic [CPU_DATA_W-1:0] tdata_o,
   output logic                  tvalid_o,
   input  logic                  tready_i,
   output logic                  fifo_threshold_o
);

   localparam int LANES = CPU_DATA_W / TDATA_W;

   logic                     clr;
   logic                     enable;
   logic                     pop;
   logic [CPU_DATA_W-1:0]    head_data;
   logic [LANES-1:0]         head_strb;
   logic                     head_last;
   logic                     empty;
   logic [FIFO_DEPTH_LOG2:0] level;

   axis_in_word_if #(.LANES(LANES)) word_if ();

   axis_in_packer #(
      .TDATA_W(TDATA_W)
   ) packer_inst (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .clr_i        (clr),
      .enable_i     (enable),
      .axis_tdata_i (axis_tdata_i),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tlast_i (axis_tlast_i),
      .axis_tready_o(axis_tready_o),
      .word         (word_if.producer)
   );

   axis_in_fifo #(
      .LANES          (LANES),
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) fifo_inst (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .clr_i      (clr),
      .word       (word_if.consumer),
      .pop_i      (pop),
      .head_data_o(head_data),
      .head_strb_o(head_strb),
      .head_last_o(head_last),
      .empty_o    (empty),
      .level_o    (level)
   );

   axis_in_regs #(
      .LANES          (LANES),
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) regs_inst (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .reg_avalid_i    (reg_avalid_i),
      .reg_addr_i      (reg_addr_i),
      .reg_wdata_i     (reg_wdata_i),
      .reg_wen_i       (reg_wen_i),
      .reg_ready_o     (reg_ready_o),
      .reg_rvalid_o    (reg_rvalid_o),
      .reg_rdata_o     (reg_rdata_o),
      .head_data_i     (head_data),
      .head_strb_i     (head_strb),
      .head_last_i     (head_last),
      .empty_i         (empty),
      .level_i         (level),
      .pop_o           (pop),
      .clr_o           (clr),
      .enable_o        (enable),
      .tdata_o         (tdata_o),
      .tvalid_o        (tvalid_o),
      .tready_i        (tready_i),
      .fifo_threshold_o(fifo_threshold_o)
   );

endmodule

// ==== dv/axis_in_properties.sv ====
`timescale 1ns/1ns

module axis_in_properties
   import axis_in_pkg::*;
(
   input logic                  clk_i,
   input logic                  rst_n_i,
   input logic                  enable_i,
   input logic                  clr_i,
   input logic                  pop_i,
   input logic                  axis_tready_o,
   input logic                  reg_avalid_i,
   input logic                  reg_wen_i,
   input logic                  reg_rvalid_o,
   input logic [CPU_DATA_W-1:0] tdata_o,
   input logic                  tvalid_o,
   input logic                  tready_i
);

   tready_low_disabled: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !enable_i |-> !axis_tready_o
   ) else $error("axis_tready_o high while disabled");

   tvalid_low_reset: assert property (
      @(posedge clk_i) !rst_n_i |=> !tvalid_o
   ) else $error("tvalid_o high during or right after reset");

   rvalid_after_read: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
         reg_rvalid_o == $past(reg_avalid_i && !reg_wen_i)
   ) else $error("reg_rvalid_o does not follow a read by one cycle");

   // Head holds while nothing pops it
   tdata_held: assert property (
      @(posedge clk_i) disable iff (!rst_n_i || clr_i)
         tvalid_o && !tready_i && !pop_i |=> $stable(tdata_o)
   ) else $error("tdata_o changed under back-pressure");

endmodule

bind axis_in_top axis_in_properties props_inst (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .enable_i     (enable),
   .clr_i        (clr),
   .pop_i        (pop),
   .axis_tready_o(axis_tready_o),
   .reg_avalid_i (reg_avalid_i),
   .reg_wen_i    (reg_wen_i),
   .reg_rvalid_o (reg_rvalid_o),
   .tdata_o      (tdata_o),
   .tvalid_o     (tvalid_o),
   .tready_i     (tready_i)
);

// ==== dv/axis_in_tb.sv ====
`timescale 1ns/1ns

module axis_in_tb
   import axis_in_pkg::*;
();

   logic                  clk_i = 1'b0;
   logic                  rst_n_i;
   logic [7:0]            axis_tdata_i;
   logic                  axis_tvalid_i;
   logic                  axis_tlast_i;
   logic                  axis_tready_o;
   logic                  reg_avalid_i;
   logic [ADDR_W-1:0]     reg_addr_i;
   logic [CPU_DATA_W-1:0] reg_wdata_i;
   logic                  reg_wen_i;
   logic                  reg_ready_o;
   logic                  reg_rvalid_o;
   logic [CPU_DATA_W-1:0] reg_rdata_o;
   logic [CPU_DATA_W-1:0] tdata_o;
   logic                  tvalid_o;
   logic                  tready_i;
   logic                  fifo_threshold_o;

   logic [7:0]  pkt_q[$];
   logic [31:0] exp_data_q[$];
   logic [3:0]  exp_strb_q[$];
   logic        exp_last_q[$];
   int          errors = 0;
   int          checks = 0;
   integer      seed = 32'h5369_591a;
   int          pkt_len[12];
   int          total_beats = 0;
   int          limit_cycles = 0;
   bit          stream_done = 1'b0;

   axis_in_top #(
      .TDATA_W        (8),
      .FIFO_DEPTH_LOG2(3)
   ) axis_in_top_inst (.*);

   always #2 clk_i = ~clk_i;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("** Error %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // Beats of pkt_q into little-endian words, tlast on the final beat
   function automatic void ref_pack();
      logic [31:0] data;
      logic [3:0]  strb;
      int          lane;
      data = '0;
      strb = '0;
      lane = 0;
      for (int i = 0; i < pkt_q.size(); i++) begin
         data[lane*8 +: 8] = pkt_q[i];
         strb[lane]        = 1'b1;
         if (lane == 3 || i == pkt_q.size() - 1) begin
            exp_data_q.push_back(data);
            exp_strb_q.push_back(strb);
            exp_last_q.push_back(i == pkt_q.size() - 1);
            data = '0;
            strb = '0;
            lane = 0;
         end else begin
            lane++;
         end
      end
   endfunction

   task automatic drop_head();
      exp_data_q.delete(0);
      exp_strb_q.delete(0);
      exp_last_q.delete(0);
   endtask

   task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
      reg_avalid_i = 1'b1;
      reg_wen_i    = 1'b1;
      reg_addr_i   = addr;
      reg_wdata_i  = data;
      @(posedge clk_i);
      #1;
      reg_avalid_i = 1'b0;
      reg_wen_i    = 1'b0;
   endtask

   task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
      reg_avalid_i = 1'b1;
      reg_wen_i    = 1'b0;
      reg_addr_i   = addr;
      @(negedge clk_i);
      check_value("reg_ready", 1'b1, reg_ready_o);
      @(posedge clk_i);
      #1;
      reg_avalid_i = 1'b0;
      while (!reg_rvalid_o) begin
         @(posedge clk_i);
         #1;
      end
      data = reg_rdata_o;
   endtask

   // Expected words are queued before the first beat goes out
   task automatic send_packet(input int n, input bit with_last);
      bit taken;
      pkt_q.delete();
      for (int i = 0; i < n; i++) begin
         pkt_q.push_back($random(seed));
      end
      if (with_last) begin
         ref_pack();
      end
      for (int i = 0; i < n; i++) begin
         axis_tdata_i  = pkt_q[i];
         axis_tvalid_i = 1'b1;
         axis_tlast_i  = with_last && (i == n - 1);
         do begin
            @(negedge clk_i);
            taken = axis_tready_o;
            @(posedge clk_i);
            #1;
         end while (!taken);
      end
      axis_tvalid_i = 1'b0;
      axis_tlast_i  = 1'b0;
   endtask

   task automatic drain_reads(input string name);
      logic [31:0] status;
      logic [31:0] data;
      while (exp_data_q.size() > 0) begin
         do begin
            reg_read(REG_STATUS, status);
         end while (status[STATUS_EMPTY_BIT]);
         check_value({name, " strb"}, exp_strb_q[0], status[3:0]);
         check_value({name, " last"}, exp_last_q[0], status[STATUS_LAST_BIT]);
         reg_read(REG_DATA, data);
         check_value({name, " data"}, exp_data_q[0], data);
         drop_head();
      end
   endtask

   // DMA pops against the expected order
   always @(posedge clk_i) begin
      if (rst_n_i && tvalid_o && tready_i) begin
         if (exp_data_q.size() == 0) begin
            errors++;
            $display("DMA popped a word that was never expected");
         end else begin
            check_value("dma_drain data", exp_data_q[0], tdata_o);
            drop_head();
         end
      end
   end

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk_i);
      $display("Timeout after %0d cycles, the tests did not finish", limit_cycles);
      $display("sim failed");
      $finish;
   end

   initial begin
      logic [31:0] status;
      rst_n_i       = 1'b0;
      axis_tdata_i  = '0;
      axis_tvalid_i = 1'b0;
      axis_tlast_i  = 1'b0;
      reg_avalid_i  = 1'b0;
      reg_addr_i    = '0;
      reg_wdata_i   = '0;
      reg_wen_i     = 1'b0;
      tready_i      = 1'b0;
      // 0..2 full, 3..6 short, 7..11 for DMA
      for (int p = 0; p < 12; p++) begin
         if (p < 3) begin
            pkt_len[p] = 4 * (1 + $unsigned($random(seed)) % 3);
         end else if (p < 7) begin
            pkt_len[p] = 4 * ($unsigned($random(seed)) % 2) + 1 + $unsigned($random(seed)) % 3;
         end else begin
            pkt_len[p] = 1 + $unsigned($random(seed)) % 12;
         end
         total_beats += pkt_len[p];
      end
      // Back-pressure and control tests add 63 beats
      limit_cycles = (total_beats + 63) * 20 + 2000;
      repeat (16) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      check_value("reset outputs", 4'b0,
                  {axis_tready_o, tvalid_o, reg_rvalid_o, fifo_threshold_o});
      reg_read(REG_THRESHOLD, status);
      check_value("reset threshold", 32'hFFFF_FFFF, status);
      reg_write(REG_ENABLE, 32'd1);

      for (int p = 0; p < 3; p++) begin
         send_packet(pkt_len[p], 1'b1);
         drain_reads("full_pkt");
      end
      for (int p = 3; p < 7; p++) begin
         send_packet(pkt_len[p], 1'b1);
         drain_reads("short_pkt");
      end

      fork
         begin
            for (int p = 7; p < 12; p++) begin
               send_packet(pkt_len[p], 1'b1);
            end
            stream_done = 1'b1;
         end
         begin
            while (!(stream_done && exp_data_q.size() == 0)) begin
               tready_i = (($random(seed) & 3) != 0);
               @(posedge clk_i);
               #1;
            end
            tready_i = 1'b0;
         end
      join

      fork
         send_packet(36, 1'b1);
         begin
            do begin
               reg_read(REG_STATUS, status);
            end while (status[31:16] < 8);
            check_value("backpressure level", 32'd8, status[31:16]);
            @(negedge clk_i);
            check_value("backpressure tready", 1'b0, axis_tready_o);
            @(posedge clk_i);
            #1;
            drain_reads("backpressure");
         end
      join

      reg_write(REG_ENABLE, 32'd0);
      axis_tdata_i  = 8'h5a;
      axis_tvalid_i = 1'b1;
      repeat (8) begin
         @(negedge clk_i);
         check_value("disabled tready", 1'b0, axis_tready_o);
         @(posedge clk_i);
         #1;
      end
      axis_tvalid_i = 1'b0;
      reg_read(REG_STATUS, status);
      check_value("disabled level", 32'd0, status[31:16]);

      reg_write(REG_ENABLE, 32'd1);
      send_packet(4, 1'b1);
      send_packet(2, 1'b0);
      reg_read(REG_STATUS, status);
      check_value("pre soft_reset level", 32'd1, status[31:16]);
      reg_write(REG_SOFT_RESET, 32'd1);
      exp_data_q.delete();
      exp_strb_q.delete();
      exp_last_q.delete();
      reg_read(REG_STATUS, status);
      check_value("soft_reset status", 32'h0000_0020, status);
      send_packet(1, 1'b1);
      drain_reads("soft_reset");

      reg_write(REG_THRESHOLD, 32'd3);
      for (int w = 1; w <= 5; w++) begin
         send_packet(4, 1'b1);
         reg_read(REG_STATUS, status);
         check_value("threshold level", w, status[31:16]);
         check_value("threshold flag", (w >= 3), fifo_threshold_o);
      end
      drain_reads("threshold");

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== project.f ====
rtl/axis_in_pkg.sv
rtl/axis_in_word_if.sv
rtl/axis_in_packer.sv
rtl/axis_in_fifo.sv
rtl/axis_in_regs.sv
rtl/axis_in_top.sv
dv/axis_in_properties.sv
dv/axis_in_tb.sv

// ==== Bender.yml ====
package:
  name: axis_in

sources:
  - files:
      - rtl/axis_in_pkg.sv
      - rtl/axis_in_word_if.sv
      - rtl/axis_in_packer.sv
      - rtl/axis_in_fifo.sv
      - rtl/axis_in_regs.sv
      - rtl/axis_in_top.sv
  - target: test
    files:
      - dv/axis_in_properties.sv
      - dv/axis_in_tb.sv
